/* project.f */
source/rv_pkg.sv
source/pipeline_stage.sv
source/decoder.sv
source/register_file.sv
source/forwarding.sv
source/alu.sv
source/core.sv
verification/core_chk.sv
verification/core_tb.sv

/* Makefile */
# Verilator flow for the RV32I integer core

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BINARY)
	./$(BINARY) 2>&1 | tee $(LOG)
	@grep -qx 'STATUS: PASS' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/core_tb.sv */
`timescale 1ns/100ps

module core_tb;

  logic        clock;
  logic        rst_n;
  logic [31:0] instr;
  logic        instr_valid;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic        retire_illegal;
  logic [5:0]  led;

  // instruction word, ISA result and out-of-scope flag per entry
  logic [31:0] prog_instr [$];
  logic [31:0] prog_result [$];
  bit          prog_illegal [$];
  int          expected_q [$];

  logic [5:0]  led_expected;
  int          error_count;
  int          check_count;

  core core_inst (
    .clock(clock),
    .rst_n(rst_n),
    .instr(instr),
    .instr_valid(instr_valid),
    .retire_valid(retire_valid),
    .retire_rd(retire_rd),
    .retire_data(retire_data),
    .retire_illegal(retire_illegal),
    .led(led)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    r_type = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    i_type = {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    u_type = {imm, rd, 7'b0110111};
  endfunction

  task automatic add_entry(input logic [31:0] word, input logic [31:0] result, input bit bad);
    prog_instr.push_back(word);
    prog_result.push_back(result);
    prog_illegal.push_back(bad);
  endtask

  task automatic load_program();
    add_entry(i_type(12'd5, 5'd0, 3'd0, 5'd1), 32'd5, 1'b0);
    add_entry(i_type(12'hFFD, 5'd0, 3'd0, 5'd2), 32'hFFFF_FFFD, 1'b0);
    add_entry(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 32'd2, 1'b0);
    add_entry(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), 32'd8, 1'b0);
    add_entry(r_type(7'h20, 5'd1, 5'd2, 3'd5, 5'd5), 32'hFFFF_FFFF, 1'b0);
    add_entry(r_type(7'h00, 5'd1, 5'd2, 3'd5, 5'd6), 32'h07FF_FFFF, 1'b0);
    add_entry(i_type(12'd4, 5'd1, 3'd1, 5'd7), 32'h0000_0050, 1'b0);
    add_entry(i_type(12'h401, 5'd2, 3'd5, 5'd8), 32'hFFFF_FFFE, 1'b0);
    add_entry(i_type(12'd28, 5'd2, 3'd5, 5'd9), 32'h0000_000F, 1'b0);
    add_entry(i_type(12'd0, 5'd2, 3'd2, 5'd10), 32'd1, 1'b0);
    add_entry(i_type(12'hFFF, 5'd1, 3'd3, 5'd11), 32'd1, 1'b0);
    add_entry(r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd12), 32'd0, 1'b0);
    add_entry(r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd13), 32'd1, 1'b0);
    add_entry(u_type(20'h12345, 5'd14), 32'h1234_5000, 1'b0);
    add_entry(i_type(12'hFFF, 5'd14, 3'd0, 5'd14), 32'h1234_4FFF, 1'b0);
    add_entry(i_type(12'h0FF, 5'd14, 3'd4, 5'd15), 32'h1234_4F00, 1'b0);
    add_entry(r_type(7'h00, 5'd1, 5'd15, 3'd6, 5'd16), 32'h1234_4F05, 1'b0);
    add_entry(r_type(7'h00, 5'd2, 5'd16, 3'd7, 5'd17), 32'h1234_4F05, 1'b0);
    add_entry(i_type(12'h7F0, 5'd17, 3'd7, 5'd18), 32'h0000_0700, 1'b0);
    add_entry(i_type(12'h800, 5'd0, 3'd6, 5'd19), 32'hFFFF_F800, 1'b0);
    add_entry(r_type(7'h00, 5'd1, 5'd1, 3'd1, 5'd20), 32'h0000_00A0, 1'b0);
    add_entry(r_type(7'h00, 5'd19, 5'd20, 3'd4, 5'd21), 32'hFFFF_F8A0, 1'b0);
    // x0 destination retires its sum but keeps reading zero
    add_entry(i_type(12'd7, 5'd1, 3'd0, 5'd0), 32'd12, 1'b0);
    add_entry(r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd22), 32'd5, 1'b0);
    // unknown opcode with nonzero sources, x31 must stay zero
    add_entry({7'h7F, 5'd2, 5'd1, 3'd6, 5'd31, 7'h7F}, 32'd0, 1'b1);
    add_entry(r_type(7'h00, 5'd0, 5'd31, 3'd0, 5'd23), 32'd0, 1'b0);
    // mul encoding is outside the integer subset
    add_entry(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd25), 32'd0, 1'b1);
    add_entry(r_type(7'h00, 5'd0, 5'd25, 3'd0, 5'd26), 32'd0, 1'b0);
    add_entry(i_type(12'd42, 5'd0, 3'd0, 5'd1), 32'd42, 1'b0);
    add_entry(i_type(12'd1, 5'd1, 3'd0, 5'd24), 32'd43, 1'b0);
  endtask

  task automatic check_retire();
    int idx;
    logic [4:0] rd_expected;
    if (expected_q.size() == 0) begin
      $display("error at %0t: retire seen with no instruction outstanding", $time);
      error_count++;
    end else begin
      idx = expected_q.pop_front();
      rd_expected = prog_instr[idx][11:7];
      check_count++;
      if (retire_rd !== rd_expected) begin
        $display("mismatch at %0t: entry %0d retire_rd %0d, expected %0d",
                 $time, idx, retire_rd, rd_expected);
        error_count++;
      end
      if (retire_illegal !== prog_illegal[idx]) begin
        $display("mismatch at %0t: entry %0d retire_illegal %0b, expected %0b",
                 $time, idx, retire_illegal, prog_illegal[idx]);
        error_count++;
      end
      if (!prog_illegal[idx] && retire_data !== prog_result[idx]) begin
        $display("mismatch at %0t: entry %0d retire_data %h, expected %h",
                 $time, idx, retire_data, prog_result[idx]);
        error_count++;
      end
      // x1 write lands on the edge after this sample
      if (!prog_illegal[idx] && rd_expected == 5'd1) begin
        led_expected = ~prog_result[idx][5:0];
      end
    end
  endtask

  // outputs are sampled mid-cycle
  always @(negedge clock) begin
    if (rst_n) begin
      check_count++;
      if (led !== led_expected) begin
        $display("mismatch at %0t: led %b, expected %b", $time, led, led_expected);
        error_count++;
      end
      if (retire_valid === 1'b1) begin
        check_retire();
      end
    end
  end

  initial begin
    int bubbles;
    int wait_cycles;
    instr = '0;
    instr_valid = 1'b0;
    rst_n = 1'b0;
    led_expected = 6'h3F;
    error_count = 0;
    check_count = 0;
    void'($urandom(46));
    load_program();

    repeat (2) @(posedge clock);
    #1 rst_n = 1'b1;
    @(negedge clock);
    check_count++;
    if (retire_valid !== 1'b0 || led !== 6'h3F) begin
      $display("mismatch at %0t: after reset retire_valid %b led %b", $time, retire_valid, led);
      error_count++;
    end

    for (int i = 0; i < prog_instr.size(); i++) begin
      @(posedge clock);
      #1;
      instr = prog_instr[i];
      instr_valid = 1'b1;
      expected_q.push_back(i);
      bubbles = $urandom_range(2, 0);
      repeat (bubbles) begin
        @(posedge clock);
        #1;
        instr = '0;
        instr_valid = 1'b0;
      end
    end
    @(posedge clock);
    #1;
    instr = '0;
    instr_valid = 1'b0;

    // drain with a bound on the wait
    wait_cycles = 0;
    while (expected_q.size() != 0 && wait_cycles < rv_pkg::retire_latency + 4) begin
      @(posedge clock);
      wait_cycles++;
    end
    if (expected_q.size() != 0) begin
      $display("timeout: %0d instructions never retired", expected_q.size());
      error_count++;
    end
    // let the last x1 write reach the leds
    repeat (2) @(posedge clock);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* verification/core_chk.sv */
`timescale 1ns/100ps

module core_chk (
  input logic                             clock,
  input logic                             rst_n,
  input logic                             instr_valid,
  input logic                             retire_valid,
  input logic [rv_pkg::reg_addr_bits-1:0] retire_rd,
  input logic                             wb_reg_write
);

  // every accepted instruction retires a fixed number of edges later
  assert property (@(posedge clock) disable iff (!rst_n)
    instr_valid |-> ##(rv_pkg::retire_latency) retire_valid)
    else $error("accepted instruction did not retire on time");

  // bubbles stay empty all the way down
  assert property (@(posedge clock) disable iff (!rst_n)
    !instr_valid |-> ##(rv_pkg::retire_latency) !retire_valid)
    else $error("retire seen for a bubble slot");

  assert property (@(posedge clock) disable iff (!rst_n)
    (retire_valid && wb_reg_write) |-> (retire_rd != '0))
    else $error("register write retired with x0 as destination");

  assert property (@(posedge clock) !rst_n |-> !retire_valid)
    else $error("retire seen while reset is asserted");

endmodule

bind core core_chk core_chk_inst (
  .clock(clock),
  .rst_n(rst_n),
  .instr_valid(instr_valid),
  .retire_valid(retire_valid),
  .retire_rd(retire_rd),
  .wb_reg_write(wb_data.reg_write)
);

/* source/core.sv */
`timescale 1ns/100ps

module core (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic [rv_pkg::xlen-1:0]          instr,
  input  logic                             instr_valid,
  output logic                             retire_valid,
  output logic [rv_pkg::reg_addr_bits-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]          retire_data,
  output logic                             retire_illegal,
  output logic [5:0]                       led
);

  rv_pkg::fetch_t fetch_in;
  rv_pkg::fetch_t fetch_out;
  logic fetch_valid;

  rv_pkg::decode_t decode_in;
  rv_pkg::decode_t ex_data;
  logic ex_valid;

  rv_pkg::execute_t execute_in;
  rv_pkg::execute_t wb_data;
  logic wb_valid;

  logic [rv_pkg::xlen-1:0] operand_a;
  logic [rv_pkg::xlen-1:0] operand_b;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [5:0] x1_value;

  assign fetch_in.instr = instr;

  pipeline_stage #(.payload_t(rv_pkg::fetch_t)) fetch_stage (
    .clock(clock),
    .rst_n(rst_n),
    .in_valid(instr_valid),
    .in_data(fetch_in),
    .out_valid(fetch_valid),
    .out_data(fetch_out)
  );

  decoder decoder_inst (
    .instr(fetch_out.instr),
    .rs1(decode_in.rs1),
    .rs2(decode_in.rs2),
    .rd(decode_in.rd),
    .immediate(decode_in.immediate),
    .use_imm(decode_in.use_imm),
    .alu_op(decode_in.alu_op),
    .reg_write(decode_in.reg_write),
    .illegal(decode_in.illegal)
  );

  // written from writeback, read in decode
  register_file register_file_inst (
    .clock(clock),
    .rst_n(rst_n),
    .rs1(decode_in.rs1),
    .rs2(decode_in.rs2),
    .rs1_data(decode_in.rs1_data),
    .rs2_data(decode_in.rs2_data),
    .rd(wb_data.rd),
    .rd_data(wb_data.result),
    .reg_write(wb_valid && wb_data.reg_write),
    .x1_value(x1_value)
  );

  pipeline_stage #(.payload_t(rv_pkg::decode_t)) decode_stage (
    .clock(clock),
    .rst_n(rst_n),
    .in_valid(fetch_valid),
    .in_data(decode_in),
    .out_valid(ex_valid),
    .out_data(ex_data)
  );

  forwarding forwarding_inst (
    .rs1(ex_data.rs1),
    .rs2(ex_data.rs2),
    .rs1_data(ex_data.rs1_data),
    .rs2_data(ex_data.rs2_data),
    .immediate(ex_data.immediate),
    .use_imm(ex_data.use_imm),
    .wb_valid(wb_valid),
    .wb_reg_write(wb_data.reg_write),
    .wb_rd(wb_data.rd),
    .wb_result(wb_data.result),
    .operand_a(operand_a),
    .operand_b(operand_b)
  );

  alu alu_inst (
    .a(operand_a),
    .b(operand_b),
    .op(ex_data.alu_op),
    .result(alu_result)
  );

  assign execute_in.rd = ex_data.rd;
  assign execute_in.result = alu_result;
  assign execute_in.reg_write = ex_data.reg_write;
  assign execute_in.illegal = ex_data.illegal;

  pipeline_stage #(.payload_t(rv_pkg::execute_t)) writeback_stage (
    .clock(clock),
    .rst_n(rst_n),
    .in_valid(ex_valid),
    .in_data(execute_in),
    .out_valid(wb_valid),
    .out_data(wb_data)
  );

  // retire mirrors the writeback slot
  assign retire_valid = wb_valid;
  assign retire_rd = wb_data.rd;
  assign retire_data = wb_data.result;
  assign retire_illegal = wb_data.illegal;

  // leds are active low
  assign led = ~x1_value;

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  rv_pkg::alu_op_t         op,
  output logic [rv_pkg::xlen-1:0] result
);

  logic [4:0] shamt;
  logic signed_less;
  logic unsigned_less;

  // shift amount from the low five bits only
  assign shamt = b[4:0];
  assign signed_less = $signed(a) < $signed(b);
  assign unsigned_less = a < b;

  always_comb begin
    case (op)
      rv_pkg::alu_add:    result = a + b;
      rv_pkg::alu_sub:    result = a - b;
      rv_pkg::alu_and:    result = a & b;
      rv_pkg::alu_or:     result = a | b;
      rv_pkg::alu_xor:    result = a ^ b;
      rv_pkg::alu_sll:    result = a << shamt;
      rv_pkg::alu_srl:    result = a >> shamt;
      rv_pkg::alu_sra:    result = $signed(a) >>> shamt;
      rv_pkg::alu_slt:    result = {{(rv_pkg::xlen-1){1'b0}}, signed_less};
      rv_pkg::alu_sltu:   result = {{(rv_pkg::xlen-1){1'b0}}, unsigned_less};
      // lui passes its upper immediate through
      rv_pkg::alu_pass_b: result = b;
      default:            result = '0;
    endcase
  end

endmodule

/* source/forwarding.sv */
`timescale 1ns/100ps

module forwarding (
  input  logic [rv_pkg::reg_addr_bits-1:0] rs1,
  input  logic [rv_pkg::reg_addr_bits-1:0] rs2,
  input  logic [rv_pkg::xlen-1:0]          rs1_data,
  input  logic [rv_pkg::xlen-1:0]          rs2_data,
  input  logic [rv_pkg::xlen-1:0]          immediate,
  input  logic                             use_imm,
  input  logic                             wb_valid,
  input  logic                             wb_reg_write,
  input  logic [rv_pkg::reg_addr_bits-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]          wb_result,
  output logic [rv_pkg::xlen-1:0]          operand_a,
  output logic [rv_pkg::xlen-1:0]          operand_b
);

  logic wb_writes;
  logic [rv_pkg::xlen-1:0] rs2_forwarded;

  // writeback result is newer than what decode read
  assign wb_writes = wb_valid && wb_reg_write && (wb_rd != '0);

  assign operand_a = (wb_writes && wb_rd == rs1) ? wb_result : rs1_data;
  assign rs2_forwarded = (wb_writes && wb_rd == rs2) ? wb_result : rs2_data;

  // immediate forms replace rs2 entirely
  assign operand_b = use_imm ? immediate : rs2_forwarded;

endmodule

/* source/register_file.sv */
`timescale 1ns/100ps

module register_file (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic [rv_pkg::reg_addr_bits-1:0] rs1,
  input  logic [rv_pkg::reg_addr_bits-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]          rs1_data,
  output logic [rv_pkg::xlen-1:0]          rs2_data,
  input  logic [rv_pkg::reg_addr_bits-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]          rd_data,
  input  logic                             reg_write,
  output logic [5:0]                       x1_value
);

  // x0 has no storage
  logic [rv_pkg::xlen-1:0] regs [1:31];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // write-through covers a reader two slots behind the writer
  function automatic logic [rv_pkg::xlen-1:0] read_port(
    input logic [rv_pkg::reg_addr_bits-1:0] idx
  );
    if (idx == '0) begin
      read_port = '0;
    end else if (reg_write && idx == rd) begin
      read_port = rd_data;
    end else begin
      read_port = regs[idx];
    end
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  assign x1_value = regs[1][5:0];

endmodule

/* source/decoder.sv */
`timescale 1ns/100ps

module decoder (
  input  logic [rv_pkg::xlen-1:0]          instr,
  output logic [rv_pkg::reg_addr_bits-1:0] rs1,
  output logic [rv_pkg::reg_addr_bits-1:0] rs2,
  output logic [rv_pkg::reg_addr_bits-1:0] rd,
  output logic [rv_pkg::xlen-1:0]          immediate,
  output logic                             use_imm,
  output rv_pkg::alu_op_t                  alu_op,
  output logic                             reg_write,
  output logic                             illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [rv_pkg::xlen-1:0] i_imm;
  logic [rv_pkg::xlen-1:0] u_imm;

  assign opcode = instr[6:0];
  assign rd = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign funct7 = instr[31:25];

  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign u_imm = {instr[31:12], 12'b0};

  // operation implied by funct3 alone
  function automatic rv_pkg::alu_op_t base_op(input logic [2:0] f3);
    case (f3)
      rv_pkg::funct3_add_sub: base_op = rv_pkg::alu_add;
      rv_pkg::funct3_sll:     base_op = rv_pkg::alu_sll;
      rv_pkg::funct3_slt:     base_op = rv_pkg::alu_slt;
      rv_pkg::funct3_sltu:    base_op = rv_pkg::alu_sltu;
      rv_pkg::funct3_xor:     base_op = rv_pkg::alu_xor;
      rv_pkg::funct3_srl_sra: base_op = rv_pkg::alu_srl;
      rv_pkg::funct3_or:      base_op = rv_pkg::alu_or;
      default:                base_op = rv_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    alu_op = base_op(funct3);
    immediate = i_imm;
    use_imm = 1'b0;
    illegal = 1'b0;
    case (opcode)
      rv_pkg::opcode_op: begin
        if (funct7 == rv_pkg::funct7_alt && funct3 == rv_pkg::funct3_add_sub) begin
          alu_op = rv_pkg::alu_sub;
        end else if (funct7 == rv_pkg::funct7_alt && funct3 == rv_pkg::funct3_srl_sra) begin
          alu_op = rv_pkg::alu_sra;
        end else if (funct7 != rv_pkg::funct7_base) begin
          illegal = 1'b1;
        end
      end
      rv_pkg::opcode_op_imm: begin
        use_imm = 1'b1;
        // only shifts constrain the upper immediate bits
        if (funct3 == rv_pkg::funct3_srl_sra && funct7 == rv_pkg::funct7_alt) begin
          alu_op = rv_pkg::alu_sra;
        end else if ((funct3 == rv_pkg::funct3_sll || funct3 == rv_pkg::funct3_srl_sra) &&
                     funct7 != rv_pkg::funct7_base) begin
          illegal = 1'b1;
        end
      end
      rv_pkg::opcode_lui: begin
        use_imm = 1'b1;
        immediate = u_imm;
        alu_op = rv_pkg::alu_pass_b;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
    // x0 destinations still retire, just without a write
    reg_write = !illegal && (rd != '0);
  end

endmodule

/* source/pipeline_stage.sv */
`timescale 1ns/100ps

module pipeline_stage #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  // valid always advances so bubbles move through as empty slots
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // payload only loads on a real instruction
  always_ff @(posedge clock) begin
    if (in_valid) begin
      out_data <= in_data;
    end
  end

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_bits = 5;
  // accept edge to retire sample edge
  localparam int retire_latency = 3;

  // major opcodes in scope
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui = 7'b0110111;

  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_sll = 3'b001;
  localparam logic [2:0] funct3_slt = 3'b010;
  localparam logic [2:0] funct3_sltu = 3'b011;
  localparam logic [2:0] funct3_xor = 3'b100;
  localparam logic [2:0] funct3_srl_sra = 3'b101;
  localparam logic [2:0] funct3_or = 3'b110;
  localparam logic [2:0] funct3_and = 3'b111;

  // funct7 selects sub and sra
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b
  } alu_op_t;

  typedef struct packed {
    logic [xlen-1:0] instr;
  } fetch_t;

  typedef struct packed {
    logic [reg_addr_bits-1:0] rd;
    logic [reg_addr_bits-1:0] rs1;
    logic [reg_addr_bits-1:0] rs2;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] immediate;
    logic use_imm;
    alu_op_t alu_op;
    logic reg_write;
    logic illegal;
  } decode_t;

  typedef struct packed {
    logic [reg_addr_bits-1:0] rd;
    logic [xlen-1:0] result;
    logic reg_write;
    logic illegal;
  } execute_t;

endpackage
